//--- logic/sdram_settings.svh
/*
 * Shared sizes for the ROM bank
 * Address widths of the bank port and both clients, plus the sample region base
 */

`ifndef SDRAM_SETTINGS_SVH
`define SDRAM_SETTINGS_SVH

// Word address on the bank port, one word is 32 bits
`define SDRAM_AW 21

// Main CPU program, halfword addressed
`define CPU_AW 20

// Sound samples, byte addressed
`define SND_AW 18

// Samples start 2 MB into the 8 MB bank
`define PCM_OFFSET 21'h08_0000

`endif

//--- logic/sdram_pkg.sv
/*
 * ROM bank types
 * Read word views, slot miss request and bank port command
 */

`include "sdram_settings.svh"

package sdram_pkg;

    // One 32-bit read word, lane 0 sits at the lowest address
    typedef union packed {
        logic [1:0][15:0] half;  // CPU view
        logic [3:0][7:0]  bytes; // Sample view
    } sdram_word_u;

    // Miss request from a slot, already offset into the bank
    typedef struct packed {
        logic [`SDRAM_AW-1:0] addr;
    } bank_req_t;

    // Bank port command
    typedef struct packed {
        logic                 rd;   // Held until ack
        logic [`SDRAM_AW-1:0] addr;
    } bank_cmd_t;

endpackage

//--- logic/rom_slot.sv
/*
 * Read-only client slot
 * Keeps the last fetched word, raises a request on a miss
 * and picks the client lane out of the cached word
 */

`timescale 1ns/1ps

`include "sdram_settings.svh"

module rom_slot #(
    parameter int                   DW     = 16,
    parameter int                   AW     = 20,
    parameter logic [`SDRAM_AW-1:0] OFFSET = '0
) (
    input  logic                     clk,
    input  logic                     rst,

    // Client side
    input  logic                     cs,
    input  logic [AW-1:0]            addr,
    output logic                     ok,
    output logic [DW-1:0]            dout,

    // Towards the arbiter
    output logic                     req_valid,
    output sdram_pkg::bank_req_t     req,
    input  logic                     req_ready,
    input  logic                     rdy,        // Only strobed for this slot
    input  sdram_pkg::sdram_word_u   data_read
);

    // Lane bits inside one 32-bit word
    localparam int LW = (DW == 16) ? 1 : 2;

    logic [`SDRAM_AW-1:0]   word_addr;
    logic [LW-1:0]          lane;

    logic                   cache_valid;
    logic [`SDRAM_AW-1:0]   cached_addr;
    sdram_pkg::sdram_word_u cached_data;

    logic                   pending;     // Request accepted, data not back yet
    logic                   hit;
    logic                   fill;
    logic                   match;
    logic                   launch;
    sdram_pkg::sdram_word_u src_word;
    logic [DW-1:0]          lane_data;

    logic                   ok_q;
    logic [AW-1:0]          ok_addr;
    logic [DW-1:0]          dout_q;

    assign word_addr = OFFSET + `SDRAM_AW'(addr[AW-1:LW]);
    assign lane      = addr[LW-1:0];

    assign hit    = cache_valid && (cached_addr == word_addr);
    assign fill   = rdy && pending && (req.addr == word_addr); // Data arriving now
    assign match  = hit || fill;
    assign launch = cs && !match && !req_valid && !pending;

    assign src_word = fill ? data_read : cached_data;

    generate
        if (DW == 16) begin : g_half
            assign lane_data = src_word.half[lane];
        end else begin : g_byte
            assign lane_data = src_word.bytes[lane];
        end
    endgenerate

    // Control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_valid   <= 1'b0;
            pending     <= 1'b0;
            cache_valid <= 1'b0;
            ok_q        <= 1'b0;
        end else begin
            ok_q <= cs && match;
            if (launch) begin
                req_valid <= 1'b1;
            end else if (req_valid && req_ready) begin
                req_valid <= 1'b0;
                pending   <= 1'b1;
            end
            if (rdy && pending) begin
                pending     <= 1'b0;
                cache_valid <= 1'b1;
            end
        end
    end

    // Cache contents and output data
    always_ff @(posedge clk) begin
        if (launch) begin
            req.addr <= word_addr;
        end
        if (rdy && pending) begin
            cached_addr <= req.addr;
            cached_data <= data_read;
        end
        ok_addr <= addr;
        dout_q  <= lane_data;
    end

    // ok drops as soon as the client moves to another address
    assign ok   = ok_q && cs && (ok_addr == addr);
    assign dout = dout_q;

    // A pending request holds until the arbiter takes it
    a_req_hold: assert property (
        @(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req)
    );

endmodule

//--- logic/bank_arbiter.sv
/*
 * Bank port arbiter for two slots
 * Alternates priority, keeps one read in flight, steers rdy to the
 * owning slot and registers the refresh enable from vertical blanking
 */

`timescale 1ns/1ps

module bank_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 lvbl,

    // Slot requests
    input  logic                 valid0,
    input  logic                 valid1,
    input  sdram_pkg::bank_req_t req0,
    input  sdram_pkg::bank_req_t req1,
    output logic                 ready0,
    output logic                 ready1,
    output logic                 rdy0,
    output logic                 rdy1,

    // Bank port
    output sdram_pkg::bank_cmd_t cmd,
    input  logic                 ack,
    input  logic                 rdy,

    output logic                 refresh_en
);

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_WAIT_ACK = 2'd1;
    localparam logic [1:0] ST_WAIT_RDY = 2'd2;

    logic [1:0]           state;
    logic                 owner;       // 1 when slot 1 owns the bank
    logic                 last;        // Slot served most recently
    logic                 sel1;
    logic                 take;
    logic                 rd_q;
    sdram_pkg::bank_req_t req_q;

    // Slot 1 wins when alone or when slot 0 went last
    assign sel1   = valid1 && (!valid0 || !last);
    assign ready0 = (state == ST_IDLE) && valid0 && !sel1;
    assign ready1 = (state == ST_IDLE) && sel1;
    assign take   = ready0 || ready1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            owner <= 1'b0;
            last  <= 1'b1;   // Slot 0 first after reset
            rd_q  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take) begin
                        state <= ST_WAIT_ACK;
                        owner <= sel1;
                        last  <= sel1;
                        rd_q  <= 1'b1;
                    end
                end
                ST_WAIT_ACK: begin
                    if (ack) begin
                        state <= ST_WAIT_RDY;
                        rd_q  <= 1'b0;
                    end
                end
                ST_WAIT_RDY: begin
                    if (rdy) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    rd_q  <= 1'b0;
                end
            endcase
        end
    end

    // Address latched with the grant, stable until ack
    always_ff @(posedge clk) begin
        if (take) begin
            req_q <= sel1 ? req1 : req0;
        end
    end

    assign cmd = '{rd: rd_q, addr: req_q.addr};

    // Read strobe only goes to the slot that asked
    assign rdy0 = rdy && (state == ST_WAIT_RDY) && !owner;
    assign rdy1 = rdy && (state == ST_WAIT_RDY) && owner;

    // Refresh only during blanking
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            refresh_en <= 1'b0;
        end else begin
            refresh_en <= ~lvbl;
        end
    end

    a_one_grant: assert property (
        @(posedge clk) disable iff (rst)
        !(ready0 && ready1)
    );

    // No second read while the first one's data is still due
    a_no_rd_before_rdy: assert property (
        @(posedge clk) disable iff (rst)
        (state == ST_WAIT_RDY) |-> !cmd.rd
    );

endmodule

//--- logic/sdram_bank.sv
/*
 * Read-only SDRAM bank with CPU program and sound sample slots
 * sharing one bank port through an arbiter
 */

`timescale 1ns/1ps

`include "sdram_settings.svh"

module sdram_bank (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 lvbl,

    // Main CPU program
    input  logic                 cpu_cs,
    input  logic [`CPU_AW-1:0]   cpu_addr,
    output logic                 cpu_ok,
    output logic [15:0]          cpu_data,

    // Sound samples
    input  logic                 snd_cs,
    input  logic [`SND_AW-1:0]   snd_addr,
    output logic                 snd_ok,
    output logic [7:0]           snd_data,

    // Bank port
    output sdram_pkg::bank_cmd_t bank,
    input  logic                 bank_ack,
    input  logic                 bank_rdy,
    input  logic [31:0]          data_read,
    output logic                 refresh_en
);

    logic                 cpu_valid;
    logic                 cpu_ready;
    logic                 cpu_rdy;
    sdram_pkg::bank_req_t cpu_req;

    logic                 snd_valid;
    logic                 snd_ready;
    logic                 snd_rdy;
    sdram_pkg::bank_req_t snd_req;

    rom_slot #(
        .DW        ( 16                  ),
        .AW        ( `CPU_AW             ),
        .OFFSET    ( {`SDRAM_AW{1'b0}}   )  // Code at the bank start
    ) u_cpu_slot (
        .clk       ( clk                 ),
        .rst       ( rst                 ),
        .cs        ( cpu_cs              ),
        .addr      ( cpu_addr            ),
        .ok        ( cpu_ok              ),
        .dout      ( cpu_data            ),
        .req_valid ( cpu_valid           ),
        .req       ( cpu_req             ),
        .req_ready ( cpu_ready           ),
        .rdy       ( cpu_rdy             ),
        .data_read ( data_read           )
    );

    rom_slot #(
        .DW        ( 8                   ),
        .AW        ( `SND_AW             ),
        .OFFSET    ( `PCM_OFFSET         )
    ) u_snd_slot (
        .clk       ( clk                 ),
        .rst       ( rst                 ),
        .cs        ( snd_cs              ),
        .addr      ( snd_addr            ),
        .ok        ( snd_ok              ),
        .dout      ( snd_data            ),
        .req_valid ( snd_valid           ),
        .req       ( snd_req             ),
        .req_ready ( snd_ready           ),
        .rdy       ( snd_rdy             ),
        .data_read ( data_read           )
    );

    bank_arbiter u_arbiter (
        .clk        ( clk                ),
        .rst        ( rst                ),
        .lvbl       ( lvbl               ),
        .valid0     ( cpu_valid          ),
        .valid1     ( snd_valid          ),
        .req0       ( cpu_req            ),
        .req1       ( snd_req            ),
        .ready0     ( cpu_ready          ),
        .ready1     ( snd_ready          ),
        .rdy0       ( cpu_rdy            ),
        .rdy1       ( snd_rdy            ),
        .cmd        ( bank               ),
        .ack        ( bank_ack           ),
        .rdy        ( bank_rdy           ),
        .refresh_en ( refresh_en         )
    );

endmodule

//--- verif/sdram_model.sv
/*
 * Behavioural SDRAM bank
 * Acks a read after a random delay, then returns address-derived data
 */

`timescale 1ns/1ps

`include "sdram_settings.svh"

module sdram_model #(
    parameter logic [31:0] SEED = 32'h1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  sdram_pkg::bank_cmd_t cmd,
    output logic                 ack,
    output logic                 rdy,
    output logic [31:0]          data_read
);

    localparam logic [1:0] M_IDLE = 2'd0;
    localparam logic [1:0] M_ACK  = 2'd1;
    localparam logic [1:0] M_DATA = 2'd2;

    logic [1:0]           phase     = M_IDLE;
    logic [2:0]           delay     = 3'd0;
    logic [31:0]          rng       = SEED;
    logic [`SDRAM_AW-1:0] addr_q    = '0;
    logic                 ack_q     = 1'b0;
    logic                 rdy_q     = 1'b0;
    logic [31:0]          data_q    = 32'h0;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Scrambled word contents, every address bit matters
    function automatic logic [31:0] word_data(input logic [`SDRAM_AW-1:0] a);
        logic [31:0] x;
        x = 32'(a) ^ 32'h5a0f_3c69;
        x = x * 32'h9e37_79b1;
        return x ^ (x >> 15);
    endfunction

    // Outputs move on the falling edge
    always @(negedge clk) begin
        ack_q <= 1'b0;
        rdy_q <= 1'b0;
        if (rst) begin
            phase <= M_IDLE;
        end else begin
            case (phase)
                M_IDLE: begin
                    if (cmd.rd) begin
                        rng = xorshift(rng);
                        delay <= 3'(rng % 3);   // Ack 1 to 3 cycles on
                        phase <= M_ACK;
                    end
                end
                M_ACK: begin
                    if (delay == 3'd0) begin
                        ack_q  <= 1'b1;
                        addr_q <= cmd.addr;
                        rng = xorshift(rng);
                        delay  <= 3'(rng % 4); // Data 1 to 4 cycles after ack
                        phase  <= M_DATA;
                    end else begin
                        delay <= delay - 3'd1;
                    end
                end
                M_DATA: begin
                    if (delay == 3'd0) begin
                        rdy_q  <= 1'b1;
                        data_q <= word_data(addr_q);
                        phase  <= M_IDLE;
                    end else begin
                        delay <= delay - 3'd1;
                    end
                end
                default: phase <= M_IDLE;
            endcase
        end
    end

    assign ack       = ack_q;
    assign rdy       = rdy_q;
    assign data_read = data_q;

endmodule

//--- verif/sdram_bank_tb.sv
/*
 * Testbench for the two-slot ROM bank
 * CPU and sample clients run side by side against a behavioural bank
 */

`timescale 1ns/1ps

`include "sdram_settings.svh"

module sdram_bank_tb;

    localparam logic [31:0] SEED           = 32'hcb11f101;
    localparam int          RESET_CYCLES   = 16;
    localparam int          CPU_TXNS       = 300;
    localparam int          SND_TXNS       = 300;
    localparam int          TIMEOUT_CYCLES = 10000; // 600 transactions x 16 plus reset

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 lvbl = 1'b1;
    logic                 lvbl_q;
    logic                 cpu_cs;
    logic [`CPU_AW-1:0]   cpu_addr;
    logic                 cpu_ok;
    logic [15:0]          cpu_data;
    logic                 snd_cs;
    logic [`SND_AW-1:0]   snd_addr;
    logic                 snd_ok;
    logic [7:0]           snd_data;
    sdram_pkg::bank_cmd_t bank;
    logic                 bank_ack;
    logic                 bank_rdy;
    logic [31:0]          data_read;
    logic                 refresh_en;

    int                   errors = 0;
    int                   cycles = 0;
    logic [31:0]          cpu_rng;
    logic [31:0]          snd_rng;

    logic [`SDRAM_AW-1:0] cpu_word;
    logic [`SDRAM_AW-1:0] snd_word;
    logic [31:0]          cpu_full;
    logic [31:0]          snd_full;
    logic [15:0]          cpu_expect;
    logic [7:0]           snd_expect;

    // Word each client saw last, i.e. what its slot holds
    logic                 cpu_seen;
    logic                 snd_seen;
    logic [`SDRAM_AW-1:0] cpu_last;
    logic [`SDRAM_AW-1:0] snd_last;
    logic                 await_rdy;  // Between bank ack and rdy

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Same contents as the bank model
    function automatic logic [31:0] word_data(input logic [`SDRAM_AW-1:0] a);
        logic [31:0] x;
        x = 32'(a) ^ 32'h5a0f_3c69;
        x = x * 32'h9e37_79b1;
        return x ^ (x >> 15);
    endfunction

    assign cpu_word   = `SDRAM_AW'(cpu_addr[`CPU_AW-1:1]);
    assign snd_word   = `PCM_OFFSET + `SDRAM_AW'(snd_addr[`SND_AW-1:2]);
    assign cpu_full   = word_data(cpu_word);
    assign snd_full   = word_data(snd_word);
    assign cpu_expect = cpu_addr[0] ? cpu_full[31:16] : cpu_full[15:0]; // Low address, low lane
    assign snd_expect = 8'(snd_full >> {snd_addr[1:0], 3'b000});

    sdram_bank dut_i (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .lvbl       ( lvbl       ),
        .cpu_cs     ( cpu_cs     ),
        .cpu_addr   ( cpu_addr   ),
        .cpu_ok     ( cpu_ok     ),
        .cpu_data   ( cpu_data   ),
        .snd_cs     ( snd_cs     ),
        .snd_addr   ( snd_addr   ),
        .snd_ok     ( snd_ok     ),
        .snd_data   ( snd_data   ),
        .bank       ( bank       ),
        .bank_ack   ( bank_ack   ),
        .bank_rdy   ( bank_rdy   ),
        .data_read  ( data_read  ),
        .refresh_en ( refresh_en )
    );

    sdram_model #(
        .SEED      ( ~SEED     )
    ) u_model (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .cmd       ( bank      ),
        .ack       ( bank_ack  ),
        .rdy       ( bank_rdy  ),
        .data_read ( data_read )
    );

    always #10 clk = ~clk;

    // Blanking for the first 10 of every 50 lines
    always @(negedge clk) begin
        lvbl <= (cycles % 50) >= 10;
    end

    // Blanking as of the previous edge
    always @(posedge clk) begin
        lvbl_q <= lvbl;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, clients still waiting, %0d errors", cycles,
                     errors);
            $display("tests failed");
            $finish;
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_seen  <= 1'b0;
            snd_seen  <= 1'b0;
            cpu_last  <= '0;
            snd_last  <= '0;
            await_rdy <= 1'b0;
        end else begin
            if (cpu_ok) begin
                cpu_seen <= 1'b1;
                cpu_last <= cpu_word;
            end
            if (snd_ok) begin
                snd_seen <= 1'b1;
                snd_last <= snd_word;
            end
            if (bank_ack) begin
                await_rdy <= 1'b1;
            end else if (bank_rdy) begin
                await_rdy <= 1'b0;
            end
        end
    end

    a_reset_low: assert property (@(posedge clk)
        rst && $past(rst) |-> !bank.rd && !cpu_ok && !snd_ok && !refresh_en)
    else begin
        errors++;
        $display("Mismatch reset outputs rd,cpu_ok,snd_ok,refresh_en: got %h expected 0",
                 $sampled({bank.rd, cpu_ok, snd_ok, refresh_en}));
    end

    a_cpu_data: assert property (@(posedge clk) disable iff (rst)
        cpu_ok |-> cpu_data == cpu_expect)
    else begin
        errors++;
        $display("Mismatch cpu_data at cpu_addr %h: got %h expected %h",
                 $sampled(cpu_addr), $sampled(cpu_data), $sampled(cpu_expect));
    end

    a_snd_data: assert property (@(posedge clk) disable iff (rst)
        snd_ok |-> snd_data == snd_expect)
    else begin
        errors++;
        $display("Mismatch snd_data at snd_addr %h: got %h expected %h",
                 $sampled(snd_addr), $sampled(snd_data), $sampled(snd_expect));
    end

    // New request to the held word
    a_cpu_hit: assert property (@(posedge clk) disable iff (rst)
        cpu_cs && (!$past(cpu_cs) || $past(cpu_addr) != cpu_addr) && cpu_seen
        && cpu_word == cpu_last |=> cpu_ok)
    else begin
        errors++;
        $display("CPU request to its cached word gave no cpu_ok one cycle later, addr %h",
                 $sampled(cpu_addr));
    end

    a_snd_hit: assert property (@(posedge clk) disable iff (rst)
        snd_cs && (!$past(snd_cs) || $past(snd_addr) != snd_addr) && snd_seen
        && snd_word == snd_last |=> snd_ok)
    else begin
        errors++;
        $display("Sound request to its cached word gave no snd_ok one cycle later, addr %h",
                 $sampled(snd_addr));
    end

    a_no_refetch: assert property (@(posedge clk) disable iff (rst)
        $rose(bank.rd) |-> !(cpu_seen && bank.addr == cpu_last)
        && !(snd_seen && bank.addr == snd_last))
    else begin
        errors++;
        $display("Bank read issued for word %h that a slot already holds",
                 $sampled(bank.addr));
    end

    a_rd_hold: assert property (@(posedge clk) disable iff (rst)
        bank.rd && !bank_ack |=> bank.rd && $stable(bank.addr))
    else begin
        errors++;
        $display("Bank rd dropped or addr moved before ack, addr now %h",
                 $sampled(bank.addr));
    end

    a_rd_gap: assert property (@(posedge clk) disable iff (rst)
        await_rdy |-> !bank.rd)
    else begin
        errors++;
        $display("Bank rd raised again between ack and rdy");
    end

    a_refresh: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> refresh_en == !$past(lvbl))
    else begin
        errors++;
        $display("Mismatch refresh_en: got %h expected %h", $sampled(refresh_en),
                 !$sampled(lvbl_q));
    end

    task automatic run_cpu_client(input int count);
        logic [`CPU_AW-1:0] next_addr;
        int                 gap;
        int                 hold;
        int                 i;
        for (i = 0; i < count; i++) begin
            cpu_rng = xorshift(cpu_rng);
            case (cpu_rng[31:30])
                2'd0:    next_addr = {cpu_addr[`CPU_AW-1:1], ~cpu_addr[0]}; // Other half
                2'd1:    next_addr = cpu_addr;
                default: next_addr = cpu_rng[`CPU_AW-1:0];
            endcase
            gap  = int'(cpu_rng[21:20]);
            hold = int'(cpu_rng[22]);
            if (cpu_rng[31:30] == 2'd1) begin
                gap = gap + 1;   // Same address only counts after cs drops
            end
            if (gap > 0) begin
                @(negedge clk);
                cpu_cs = 1'b0;
                repeat (gap - 1) @(negedge clk);
            end
            @(negedge clk);
            cpu_cs   = 1'b1;
            cpu_addr = next_addr;
            @(negedge clk);
            while (!cpu_ok) @(negedge clk);
            repeat (hold) @(negedge clk);
        end
        @(negedge clk);
        cpu_cs = 1'b0;
    endtask

    task automatic run_snd_client(input int count);
        logic [`SND_AW-1:0] next_addr;
        int                 gap;
        int                 hold;
        int                 i;
        for (i = 0; i < count; i++) begin
            snd_rng = xorshift(snd_rng);
            case (snd_rng[31:30])
                2'd0:    next_addr = {snd_addr[`SND_AW-1:2], snd_addr[1:0] + 2'd1};
                2'd1:    next_addr = snd_addr;
                default: next_addr = snd_rng[`SND_AW-1:0];
            endcase
            gap  = int'(snd_rng[21:20]);
            hold = int'(snd_rng[22]);
            if (snd_rng[31:30] == 2'd1) begin
                gap = gap + 1;
            end
            if (gap > 0) begin
                @(negedge clk);
                snd_cs = 1'b0;
                repeat (gap - 1) @(negedge clk);
            end
            @(negedge clk);
            snd_cs   = 1'b1;
            snd_addr = next_addr;
            @(negedge clk);
            while (!snd_ok) @(negedge clk);
            repeat (hold) @(negedge clk);
        end
        @(negedge clk);
        snd_cs = 1'b0;
    endtask

    initial begin
        rst      = 1'b1;
        cpu_cs   = 1'b1;    // Both clients already asking while in reset
        cpu_addr = '0;
        snd_cs   = 1'b1;
        snd_addr = '0;
        cpu_rng  = SEED;
        snd_rng  = xorshift(SEED);
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        // First requests are served once reset lets go
        while (!(cpu_ok && snd_ok)) @(negedge clk);
        // Both clients at once so misses collide on the bank
        fork
            run_cpu_client(CPU_TXNS);
            run_snd_client(SND_TXNS);
        join
        repeat (4) @(negedge clk);
        $display("Finished %0d transactions in %0d cycles with %0d errors",
                 CPU_TXNS + SND_TXNS, cycles, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+logic
logic/sdram_pkg.sv
logic/rom_slot.sv
logic/bank_arbiter.sv
logic/sdram_bank.sv
verif/sdram_model.sv
verif/sdram_bank_tb.sv

//--- run.sh
#!/bin/sh
# Build the ROM bank testbench with Verilator, run it, judge the log

verilator --binary --timing --assert -f vlog.f --top-module sdram_bank_tb \
    -Mdir obj_dir -o sdram_bank_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sdram_bank_sim > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation aborted"; exit 1; }

cat sim.log
grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; }
echo "PASS"
exit 0
